//--- vlog.f
hdl/conv_pkg.sv
hdl/param_loader.sv
hdl/window_gather.sv
hdl/mac_array.sv
hdl/result_writer.sv
hdl/conv_layer_top.sv
testbench/conv_layer_props.sv
testbench/tb_conv_layer.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the conv layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_conv_layer -f vlog.f -o sim_conv_layer \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_conv_layer > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

//--- testbench/tb_conv_layer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_layer import conv_pkg::*; ;

    localparam int          FRAC_BITS      = 7;
    localparam int          OUT_ADDR_W     = 6;
    localparam logic [31:0] SEED           = 32'd89598;
    localparam int          NUM_TILES      = 1 + 80 + 4 + 8 + 16;
    localparam int          TIMEOUT_CYCLES = NUM_TILES + 200;

    typedef struct packed {
        logic [OUT_ADDR_W-1:0] addr;
        pixel_quad_t           quad;
    } exp_entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  weight_wr;
    logic [WORD_W-1:0]     weight_word;
    logic                  bias_wr;
    logic [BW_PER_PARAM-1:0] bias;
    logic                  tile_valid;
    act_tile_t             tile;
    logic                  sram_wen_b;
    logic [OUT_ADDR_W-1:0] sram_waddr_b;
    pixel_quad_t           sram_wdata_b;

    // testbench copy of the parameter state
    param_t                w_model [WEIGHT_NUM];
    param_t                bias_model;
    act_t                  cur_plane [CH_NUM][4][4];
    exp_entry_t            exp_q [$];
    string                 name_q [$];
    logic [OUT_ADDR_W-1:0] exp_addr = '0;
    logic [31:0]           rng;
    string                 test_name;
    int                    check_count = 0;
    int                    cycle_count = 0;

    conv_layer_top #(
        .FRAC_BITS  (FRAC_BITS),
        .OUT_ADDR_W (OUT_ADDR_W)
    ) u_conv_layer_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .weight_wr    (weight_wr),
        .weight_word  (weight_word),
        .bias_wr      (bias_wr),
        .bias         (bias),
        .tile_valid   (tile_valid),
        .tile         (tile),
        .sram_wen_b   (sram_wen_b),
        .sram_waddr_b (sram_waddr_b),
        .sram_wdata_b (sram_wdata_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [WORD_W-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[3:0], lo};
    endfunction

    // 2x2 groups a0..a3 in raster order, channel 0 in the top byte of each group
    function automatic act_tile_t pack_tile(input act_t pl [CH_NUM][4][4]);
        logic [127:0] g [4];
        int           gi;
        int           idx;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    gi  = (y / 2) * 2 + x / 2;
                    idx = c * ACT_PER_ADDR + (y % 2) * 2 + x % 2;
                    g[gi][127 - idx * 8 -: 8] = pl[c][y][x];
                end
            end
        end
        return {g[0], g[1], g[2], g[3]};
    endfunction

    // expected 2x2 block, sums wrap at ACC_W bits
    function automatic pixel_quad_t ref_tile(input param_t w [WEIGHT_NUM], input param_t b,
                                             input act_t pl [CH_NUM][4][4]);
        int                      acc;
        int                      shifted;
        logic signed [ACC_W-1:0] tot;
        logic [7:0]              px [4];
        for (int p = 0; p < 4; p++) begin
            acc = 0;
            for (int c = 0; c < CH_NUM; c++) begin
                for (int r = 0; r < 3; r++) begin
                    for (int s = 0; s < 3; s++) begin
                        acc = acc + int'(pl[c][p / 2 + r][p % 2 + s])
                            * int'(w[c * WEIGHT_PER_ADDR + r * 3 + s]);
                    end
                end
            end
            acc     = acc + int'(b) * (1 << FRAC_BITS) + (1 << (FRAC_BITS - 1));
            tot     = acc[ACC_W-1:0];
            shifted = int'(tot) >>> FRAC_BITS;
            if (shifted < 0) begin
                px[p] = 8'd0;
            end else if (shifted > ACT_MAX) begin
                px[p] = 8'(ACT_MAX);
            end else begin
                px[p] = 8'(shifted);
            end
        end
        return {px[0], px[1], px[2], px[3]};
    endfunction

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expv, input logic [31:0] actv);
        $display("CHECK FAILED %s %s expected %h actual %h", name, what, expv, actv);
        stop_run();
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            weight_wr  <= 1'b0;
            bias_wr    <= 1'b0;
            tile_valid <= 1'b0;
        end
    endtask

    task automatic load_weight(input logic [WORD_W-1:0] word);
        @(posedge clk);
        weight_wr   <= 1'b1;
        weight_word <= word;
        bias_wr     <= 1'b0;
        tile_valid  <= 1'b0;
        for (int i = 0; i < WEIGHT_NUM - WEIGHT_PER_ADDR; i++) begin
            w_model[i] = w_model[i + WEIGHT_PER_ADDR];
        end
        for (int k = 0; k < WEIGHT_PER_ADDR; k++) begin
            w_model[WEIGHT_NUM - WEIGHT_PER_ADDR + k] = param_t'(word[WORD_W - 1 - 4 * k -: 4]);
        end
    endtask

    task automatic load_bias(input param_t b);
        @(posedge clk);
        weight_wr  <= 1'b0;
        bias_wr    <= 1'b1;
        bias       <= b;
        tile_valid <= 1'b0;
        bias_model = b;
    endtask

    task automatic fill_random();
        logic [31:0] r;
        for (int c = 0; c < CH_NUM; c++) begin
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    r = next_rand();
                    cur_plane[c][y][x] = act_t'(r[15:8]);
                end
            end
        end
    endtask

    task automatic fill_const(input act_t v);
        for (int c = 0; c < CH_NUM; c++) begin
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    cur_plane[c][y][x] = v;
                end
            end
        end
    endtask

    task automatic send_tile();
        exp_entry_t e;
        @(posedge clk);
        weight_wr  <= 1'b0;
        bias_wr    <= 1'b0;
        tile_valid <= 1'b1;
        tile       <= pack_tile(cur_plane);
        e.quad   = ref_tile(w_model, bias_model, cur_plane);
        e.addr   = exp_addr;
        exp_addr = exp_addr + 1'b1;
        exp_q.push_back(e);
        name_q.push_back(test_name);
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        idle(2);
    endtask

    // scoreboard, outputs are settled by the falling edge
    always @(negedge clk) begin : compare_writes
        exp_entry_t e;
        string      nm;
        if (rst_n && sram_wen_b === 1'b0) begin
            assert (exp_q.size() > 0)
            else report_error("write enable went low with no result pending");
            e  = exp_q.pop_front();
            nm = name_q.pop_front();
            assert (sram_wdata_b === e.quad)
            else report_mismatch(nm, "data", 32'(e.quad), 32'(sram_wdata_b));
            assert (sram_waddr_b === e.addr)
            else report_mismatch(nm, "address", 32'(e.addr), 32'(sram_waddr_b));
            check_count++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error("timeout, the run did not finish within the cycle limit");
        end
    end

    initial begin
        rng         = SEED;
        rst_n       = 1'b0;
        weight_wr   = 1'b0;
        weight_word = '0;
        bias_wr     = 1'b0;
        bias        = '0;
        tile_valid  = 1'b0;
        tile        = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "single_tile";
        for (int i = 0; i < CH_NUM; i++) begin
            load_weight(rand_word());
        end
        load_bias(param_t'(next_rand() & 32'hf));
        idle(2);
        fill_random();
        send_tile();
        wait_drain();

        // back to back, address wraps past 63
        test_name = "stream";
        for (int i = 0; i < 80; i++) begin
            fill_random();
            send_tile();
        end
        wait_drain();

        test_name = "clamp";
        for (int i = 0; i < CH_NUM; i++) begin
            load_weight({WEIGHT_PER_ADDR{4'h7}});
        end
        load_bias(param_t'(3));
        idle(2);
        fill_const(act_t'(127));
        send_tile();
        fill_const(act_t'(100));
        send_tile();
        fill_const(act_t'(-128));
        send_tile();
        fill_const(act_t'(-100));
        send_tile();
        wait_drain();

        test_name = "reload";
        for (int i = 0; i < CH_NUM; i++) begin
            load_weight(rand_word());
        end
        load_bias(param_t'(next_rand() & 32'hf));
        idle(2);
        for (int i = 0; i < 2; i++) begin
            fill_random();
            send_tile();
        end
        // fifth word pushes channel 0's kernel out
        load_weight(rand_word());
        idle(2);
        for (int i = 0; i < 6; i++) begin
            fill_random();
            send_tile();
        end
        wait_drain();

        test_name = "bias_round";
        for (int i = 0; i < CH_NUM; i++) begin
            load_weight('0);
        end
        for (int b = -8; b < 8; b++) begin
            load_bias(param_t'(b));
            idle(2);
            fill_random();
            send_tile();
            // stage 3 must see this bias before the next load
            idle(3);
        end
        wait_drain();

        if (check_count == NUM_TILES && exp_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_error("number of writes does not match the number of tiles sent");
        end
    end

endmodule

`default_nettype wire

//--- testbench/conv_layer_props.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer_props #(
    parameter int OUT_ADDR_W = 6
) (
    input wire                  clk,
    input wire                  rst_n,
    input wire                  tile_valid,
    input wire                  sram_wen_b,
    input wire [OUT_ADDR_W-1:0] sram_waddr_b
);

    // write port idle right after reset
    wen_idle_after_reset: assert property (@(posedge clk) !rst_n |=> sram_wen_b)
        else $error("write enable active in the cycle after reset");

    // single tile pulse five samples back gives one write now
    write_follows_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(tile_valid, 5) && !$past(tile_valid, 4) && !$past(tile_valid, 6))
            |-> !sram_wen_b)
        else $error("no write where a lone tile should land");

    write_lasts_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (!sram_wen_b && $past(tile_valid, 5) && !$past(tile_valid, 4)
            && !$past(tile_valid, 6)) |=> sram_wen_b)
        else $error("write enable held low longer than one cycle for a lone tile");

    addr_steps_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        !sram_wen_b |=> sram_waddr_b == OUT_ADDR_W'($past(sram_waddr_b) + 1'b1))
        else $error("write address did not advance by one after a write");

endmodule

bind conv_layer_top conv_layer_props #(
    .OUT_ADDR_W (OUT_ADDR_W)
) u_conv_layer_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .tile_valid   (tile_valid),
    .sram_wen_b   (sram_wen_b),
    .sram_waddr_b (sram_waddr_b)
);

`default_nettype wire

//--- hdl/conv_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top import conv_pkg::*; #(
    parameter int FRAC_BITS  = 7,
    parameter int OUT_ADDR_W = 6
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     weight_wr,
    input  wire [WORD_W-1:0]        weight_word,
    input  wire                     bias_wr,
    input  wire [BW_PER_PARAM-1:0]  bias,
    input  wire                     tile_valid,
    input  wire act_tile_t          tile,
    output logic                    sram_wen_b,
    output logic [OUT_ADDR_W-1:0]   sram_waddr_b,
    output pixel_quad_t             sram_wdata_b
);

    param_t                     weights [WEIGHT_NUM];
    param_t                     bias_q;
    window_t [0:PIX_PER_TILE-1] win;
    logic                       win_valid;
    pixel_quad_t                pix;
    logic                       pix_valid;

    param_loader u_param_loader (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_wr   (weight_wr),
        .weight_word (weight_word),
        .bias_wr     (bias_wr),
        .bias        (bias),
        .weights     (weights),
        .bias_q      (bias_q)
    );

    window_gather u_window_gather (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_valid (tile_valid),
        .tile       (tile),
        .win        (win),
        .win_valid  (win_valid)
    );

    mac_array #(
        .FRAC_BITS (FRAC_BITS)
    ) u_mac_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .win       (win),
        .win_valid (win_valid),
        .weights   (weights),
        .bias_q    (bias_q),
        .pix       (pix),
        .pix_valid (pix_valid)
    );

    result_writer #(
        .OUT_ADDR_W (OUT_ADDR_W)
    ) u_result_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix          (pix),
        .pix_valid    (pix_valid),
        .sram_wen_b   (sram_wen_b),
        .sram_waddr_b (sram_waddr_b),
        .sram_wdata_b (sram_wdata_b)
    );

endmodule

`default_nettype wire

//--- hdl/result_writer.sv
`timescale 1ns/1ps
`default_nettype none

module result_writer import conv_pkg::*; #(
    parameter int OUT_ADDR_W = 6
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pixel_quad_t        pix,
    input  wire                     pix_valid,
    output logic                    sram_wen_b,
    output logic [OUT_ADDR_W-1:0]   sram_waddr_b,
    output pixel_quad_t             sram_wdata_b
);

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            sram_wdata_b <= pix;
        end
    end

    // active low, one cycle per result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_wen_b <= 1'b1;
        end else begin
            sram_wen_b <= !pix_valid;
        end
    end

    // address holds during the write, steps right after it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_waddr_b <= '0;
        end else if (!sram_wen_b) begin
            sram_waddr_b <= sram_waddr_b + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array import conv_pkg::*; #(
    parameter int FRAC_BITS = 7
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire window_t [0:PIX_PER_TILE-1] win,
    input  wire                             win_valid,
    input  wire param_t                     weights [WEIGHT_NUM],
    input  wire param_t                     bias_q,
    output pixel_quad_t                     pix,
    output logic                            pix_valid
);

    localparam int   K_DIM    = 3;
    localparam int   PART_NUM = WEIGHT_NUM / K_DIM;
    // half an lsb of the output scale
    localparam acc_t ROUND    = acc_t'(1 << (FRAC_BITS - 1));

    acc_t                  part_d [PIX_PER_TILE][PART_NUM];
    acc_t                  part_q [PIX_PER_TILE][PART_NUM];
    acc_t                  sum_d  [PIX_PER_TILE];
    acc_t                  sum_q  [PIX_PER_TILE];
    acc_t                  bias_sh;
    acc_t                  pre_sh [PIX_PER_TILE];
    acc_t                  scaled [PIX_PER_TILE];
    logic [BW_PER_ACT-1:0] res    [PIX_PER_TILE];
    logic                  v1;
    logic                  v2;

    // stage 1: one kernel row of one channel per partial sum
    always_comb begin
        act_t   a;
        param_t w;
        for (int p = 0; p < PIX_PER_TILE; p++) begin
            for (int i = 0; i < PART_NUM; i++) begin
                part_d[p][i] = '0;
                for (int j = 0; j < K_DIM; j++) begin
                    a = win[p].ch[i / K_DIM][(i % K_DIM) * K_DIM + j];
                    w = weights[K_DIM * i + j];
                    part_d[p][i] = part_d[p][i] + a * w;
                end
            end
        end
    end

    // stage 2: total, wraps at ACC_W
    always_comb begin
        for (int p = 0; p < PIX_PER_TILE; p++) begin
            sum_d[p] = '0;
            for (int i = 0; i < PART_NUM; i++) begin
                sum_d[p] = sum_d[p] + part_q[p][i];
            end
        end
    end

    // stage 3: bias, round, arithmetic shift, clamp
    always_comb begin
        bias_sh = acc_t'(bias_q) <<< FRAC_BITS;
        for (int p = 0; p < PIX_PER_TILE; p++) begin
            pre_sh[p] = sum_q[p] + bias_sh + ROUND;
            scaled[p] = pre_sh[p] >>> FRAC_BITS;
            if (scaled[p] < 0) begin
                res[p] = '0;
            end else if (scaled[p] > ACT_MAX) begin
                res[p] = BW_PER_ACT'(ACT_MAX);
            end else begin
                res[p] = scaled[p][BW_PER_ACT-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        part_q <= part_d;
        sum_q  <= sum_d;
        pix    <= {res[0], res[1], res[2], res[3]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            v1        <= win_valid;
            v2        <= v1;
            pix_valid <= v2;
        end
    end

endmodule

`default_nettype wire

//--- hdl/window_gather.sv
`timescale 1ns/1ps
`default_nettype none

module window_gather import conv_pkg::*; (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             tile_valid,
    input  wire act_tile_t                  tile,
    output window_t [0:PIX_PER_TILE-1]      win,
    output logic                            win_valid
);

    localparam int TILE_DIM = 4;
    localparam int K_DIM    = 3;
    localparam int GRP_DIM  = 2;
    localparam int OUT_DIM  = TILE_DIM - K_DIM + 1;

    act_tile_t  tile_q;
    bank_word_t grp   [GRP_DIM * GRP_DIM];
    act_t       plane [CH_NUM][TILE_DIM][TILE_DIM];

    always_ff @(posedge clk) begin
        if (tile_valid) begin
            tile_q <= tile;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= tile_valid;
        end
    end

    // group order is top-left, top-right, bottom-left, bottom-right
    always_comb begin
        grp[0] = tile_q.a0;
        grp[1] = tile_q.a1;
        grp[2] = tile_q.a2;
        grp[3] = tile_q.a3;
    end

    // rebuild each channel as a plain 4x4 plane
    always_comb begin
        for (int c = 0; c < CH_NUM; c++) begin
            for (int y = 0; y < TILE_DIM; y++) begin
                for (int x = 0; x < TILE_DIM; x++) begin
                    plane[c][y][x] =
                        grp[(y / GRP_DIM) * GRP_DIM + x / GRP_DIM]
                            .ch[c][(y % GRP_DIM) * GRP_DIM + x % GRP_DIM];
                end
            end
        end
    end

    // output pixel p sits at row p/2, column p%2 of the 2x2 block
    always_comb begin
        for (int p = 0; p < PIX_PER_TILE; p++) begin
            for (int c = 0; c < CH_NUM; c++) begin
                for (int r = 0; r < K_DIM; r++) begin
                    for (int s = 0; s < K_DIM; s++) begin
                        win[p].ch[c][r * K_DIM + s] =
                            plane[c][p / OUT_DIM + r][p % OUT_DIM + s];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/param_loader.sv
`timescale 1ns/1ps
`default_nettype none

module param_loader import conv_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     weight_wr,
    input  wire [WORD_W-1:0]        weight_word,
    input  wire                     bias_wr,
    input  wire [BW_PER_PARAM-1:0]  bias,
    output param_t                  weights [WEIGHT_NUM],
    output param_t                  bias_q
);

    localparam int KEEP_NUM = WEIGHT_NUM - WEIGHT_PER_ADDR;

    // incoming kernel slice, top nibble is position (0,0)
    param_t slot_in [WEIGHT_PER_ADDR];

    always_comb begin
        for (int k = 0; k < WEIGHT_PER_ADDR; k++) begin
            slot_in[k] = weight_word[WORD_W - 1 - k * BW_PER_PARAM -: BW_PER_PARAM];
        end
    end

    // slot k holds the kernel of input channel k
    // each write drops slot 0 and appends the new slice at slot 3
    always_ff @(posedge clk) begin
        if (weight_wr) begin
            for (int i = 0; i < KEEP_NUM; i++) begin
                weights[i] <= weights[i + WEIGHT_PER_ADDR];
            end
            for (int k = 0; k < WEIGHT_PER_ADDR; k++) begin
                weights[KEEP_NUM + k] <= slot_in[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bias_q <= '0;
        end else if (bias_wr) begin
            bias_q <= bias;
        end
    end

endmodule

`default_nettype wire

//--- hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    localparam int CH_NUM          = 4;
    localparam int ACT_PER_ADDR    = 4;
    localparam int BW_PER_ACT      = 8;
    localparam int BW_PER_PARAM    = 4;
    localparam int WEIGHT_PER_ADDR = 9;
    localparam int ACC_W           = BW_PER_ACT + BW_PER_PARAM;
    localparam int ACT_MAX         = 127;

    // derived sizes
    localparam int WEIGHT_NUM   = CH_NUM * WEIGHT_PER_ADDR;
    localparam int WORD_W       = WEIGHT_PER_ADDR * BW_PER_PARAM;
    localparam int PIX_PER_TILE = 4;

    typedef logic signed [BW_PER_ACT-1:0]   act_t;
    typedef logic signed [BW_PER_PARAM-1:0] param_t;
    typedef logic signed [ACC_W-1:0]        acc_t;

    // one bank word: ch[0] lands in the top bits, pixel (0,0) first in each group
    typedef struct packed {
        act_t [0:CH_NUM-1][0:ACT_PER_ADDR-1] ch;
    } bank_word_t;

    // 4x4 tile as four 2x2 groups
    typedef struct packed {
        bank_word_t a0;
        bank_word_t a1;
        bank_word_t a2;
        bank_word_t a3;
    } act_tile_t;

    // 3x3 window per channel, row-major
    typedef struct packed {
        act_t [0:CH_NUM-1][0:WEIGHT_PER_ADDR-1] ch;
    } window_t;

    typedef struct packed {
        logic [BW_PER_ACT-1:0] p00;
        logic [BW_PER_ACT-1:0] p01;
        logic [BW_PER_ACT-1:0] p10;
        logic [BW_PER_ACT-1:0] p11;
    } pixel_quad_t;

endpackage

`default_nettype wire
